// File: burst_reader.sv
// --------------------------------------------------------------------------
// burst reader
// drains released beats into an output queue and drives the output stream
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module burst_reader #(
  parameter int BURST_LEN = dram_fifo_cfg_pkg::DEF_BURST_LEN
) (
  input  logic                              ddr3_axi_clk,
  input  logic                              i_rst,
  // ring read side
  input  logic                              i_has_released,
  output logic                              o_pop,
  input  dram_fifo_types_pkg::mem_rd_t      i_rd,
  // output stream
  output dram_fifo_types_pkg::stream_beat_t o_m_beat,
  output logic                              o_m_valid,
  input  logic                              i_m_ready
);

  import dram_fifo_types_pkg::*;

  localparam int QDEPTH = 2 * BURST_LEN;          // room for two groups
  localparam int PTR_W  = $clog2(QDEPTH);
  localparam int CNT_W  = $clog2(QDEPTH + 1);     // holds 0..QDEPTH

  stream_beat_t     q_mem [QDEPTH];               // output queue storage
  logic [PTR_W-1:0] q_wr_ptr;
  logic [PTR_W-1:0] q_rd_ptr;
  logic [CNT_W-1:0] q_cnt;                        // beats sitting in the queue
  logic [CNT_W-1:0] occ_cnt;                      // queued plus in flight
  logic [CNT_W-1:0] occ_nxt;
  logic             out_fire;                     // output transfer this cycle

  // --------------------------------------------------------------------------
  // pop control
  // --------------------------------------------------------------------------
  // a slot is reserved at pop time, so a pop per cycle never overruns
  assign o_pop    = i_has_released && (occ_cnt != CNT_W'(QDEPTH));
  assign out_fire = o_m_valid & i_m_ready;

  always_comb begin
    occ_nxt = occ_cnt;
    if (o_pop)    occ_nxt = occ_nxt + CNT_W'(1);
    if (out_fire) occ_nxt = occ_nxt - CNT_W'(1);
  end

  // --------------------------------------------------------------------------
  // queue control
  // --------------------------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_rst) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_cnt    <= '0;
      occ_cnt  <= '0;
    end else begin
      occ_cnt <= occ_nxt;
      if (i_rd.valid) begin                       // read data lands in queue
        q_wr_ptr <= (q_wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : q_wr_ptr + PTR_W'(1);
      end
      if (out_fire) begin
        q_rd_ptr <= (q_rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : q_rd_ptr + PTR_W'(1);
      end
      case ({i_rd.valid, out_fire})
        2'b10:   q_cnt <= q_cnt + CNT_W'(1);
        2'b01:   q_cnt <= q_cnt - CNT_W'(1);
        default: q_cnt <= q_cnt;                  // none or both
      endcase
    end
  end

  // queue payload
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_rd.valid) q_mem[q_wr_ptr] <= i_rd.beat;
  end

  // --------------------------------------------------------------------------
  // output stream
  // --------------------------------------------------------------------------
  assign o_m_valid = (q_cnt != '0);
  assign o_m_beat  = q_mem[q_rd_ptr];             // head of queue

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  // credit taken at pop must cover the beat arriving a cycle later
  a_q_no_overflow : assert property (
    @(posedge ddr3_axi_clk) disable iff (i_rst)
    !(i_rd.valid && (q_cnt == CNT_W'(QDEPTH)) && !out_fire)
  ) else $error("burst_reader: output queue overflow");

endmodule : burst_reader

// File: burst_writer.sv
// --------------------------------------------------------------------------
// burst writer
// stores accepted beats in the ring and releases them per group or on timeout
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module burst_writer #(
  parameter int BURST_LEN = dram_fifo_cfg_pkg::DEF_BURST_LEN,
  parameter int TIMEOUT   = dram_fifo_cfg_pkg::DEF_TIMEOUT
) (
  input  logic                              ddr3_axi_clk,
  input  logic                              i_rst,
  // input stream
  input  dram_fifo_types_pkg::stream_beat_t i_s_beat,
  input  logic                              i_s_valid,
  output logic                              o_s_ready,
  // ring write side
  input  logic                              i_full,
  output dram_fifo_types_pkg::mem_wr_t      o_wr
);

  import dram_fifo_types_pkg::*;

  localparam int CNT_W = $clog2(BURST_LEN + 1);  // holds 0..BURST_LEN
  localparam int TMR_W = $clog2(TIMEOUT + 1);    // holds 0..TIMEOUT

  logic             accept;     // beat transfers this cycle
  logic             rel_full;   // this beat completes a group
  logic             rel_tmo;    // idle timer expired with beats pending
  logic [CNT_W-1:0] unrel_cnt;  // beats written but not yet released
  logic [TMR_W-1:0] idle_cnt;   // cycles since the last acceptance

  // --------------------------------------------------------------------------
  // handshake and release decision
  // --------------------------------------------------------------------------
  assign o_s_ready = ~i_full;                    // room in ring means ready
  assign accept    = i_s_valid & o_s_ready;

  // group closes on the edge that brings the count to BURST_LEN
  assign rel_full = accept && (unrel_cnt == CNT_W'(BURST_LEN - 1));

  // exactly TIMEOUT edges after the last acceptance
  assign rel_tmo = !accept && (unrel_cnt != '0) &&
                   (idle_cnt == TMR_W'(TIMEOUT - 1));

  always_comb begin
    o_wr.beat = i_s_beat;                        // data goes straight to memory
    o_wr.we   = accept;                          // written at the same edge
    o_wr.rel  = rel_full | rel_tmo;              // publish pending beats
  end

  // --------------------------------------------------------------------------
  // pending count and idle timer
  // --------------------------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_rst) begin
      unrel_cnt <= '0;
      idle_cnt  <= '0;
    end else begin
      if (o_wr.rel) begin
        unrel_cnt <= '0;                         // everything now visible
      end else if (accept) begin
        unrel_cnt <= unrel_cnt + CNT_W'(1);
      end

      if (accept || o_wr.rel) begin
        idle_cnt <= '0;                          // restart on traffic or flush
      end else if (unrel_cnt != '0) begin
        idle_cnt <= idle_cnt + TMR_W'(1);        // only runs while beats wait
      end
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  // the count must close a group before passing its size
  a_unrel_bound : assert property (
    @(posedge ddr3_axi_clk) disable iff (i_rst)
    unrel_cnt <= CNT_W'(BURST_LEN)
  ) else $error("burst_writer: unreleased count above group size");

endmodule : burst_writer

// File: dram_fifo_cfg_pkg.sv
// --------------------------------------------------------------------------
// stream FIFO sizing constants
// widths and the default burst, timeout and ring depth of the top level
// --------------------------------------------------------------------------

package dram_fifo_cfg_pkg;

  // --------------------------------------------------------------------------
  // stream word
  // --------------------------------------------------------------------------
  localparam int DATA_W = 64;           // tdata width of one beat

  // --------------------------------------------------------------------------
  // release policy defaults
  // --------------------------------------------------------------------------
  // a group leaves the write side once this many beats are waiting
  localparam int DEF_BURST_LEN = 8;     // beats per release group
  // partial groups are flushed after this many idle cycles
  localparam int DEF_TIMEOUT   = 28;    // cycles since last accepted beat

  // --------------------------------------------------------------------------
  // ring memory
  // --------------------------------------------------------------------------
  localparam int DEF_DEPTH_LOG2 = 6;    // 64 slots by default

endpackage : dram_fifo_cfg_pkg

// File: dram_fifo_top.f
dram_fifo_cfg_pkg.sv
dram_fifo_types_pkg.sv
burst_writer.sv
ring_buffer.sv
burst_reader.sv
dram_fifo_top.sv
tb_dram_fifo_top.sv

// File: dram_fifo_top.sv
// --------------------------------------------------------------------------
// stream FIFO top level
// writer, ring memory and reader on one clock, sized by top parameters
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module dram_fifo_top #(
  parameter int BURST_LEN  = dram_fifo_cfg_pkg::DEF_BURST_LEN,
  parameter int TIMEOUT    = dram_fifo_cfg_pkg::DEF_TIMEOUT,
  parameter int DEPTH_LOG2 = dram_fifo_cfg_pkg::DEF_DEPTH_LOG2
) (
  input  logic                              ddr3_axi_clk,
  input  logic                              i_rst,
  // input stream
  input  dram_fifo_types_pkg::stream_beat_t i_s_beat,
  input  logic                              i_s_valid,
  output logic                              o_s_ready,
  // output stream
  output dram_fifo_types_pkg::stream_beat_t o_m_beat,
  output logic                              o_m_valid,
  input  logic                              i_m_ready
);

  import dram_fifo_types_pkg::*;

  mem_wr_t wr;            // writer to ring
  logic    full;          // ring has no free slot
  logic    pop;           // reader takes oldest released beat
  logic    has_released;  // released beats are waiting
  mem_rd_t rd;            // popped beat, one cycle later

  burst_writer #(
    .BURST_LEN (BURST_LEN),
    .TIMEOUT   (TIMEOUT)
  ) u_burst_writer (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst        (i_rst),
    .i_s_beat     (i_s_beat),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .i_full       (full),
    .o_wr         (wr)
  );

  ring_buffer #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) u_ring_buffer (
    .ddr3_axi_clk   (ddr3_axi_clk),
    .i_rst          (i_rst),
    .i_wr           (wr),
    .o_full         (full),
    .i_pop          (pop),
    .o_has_released (has_released),
    .o_rd           (rd)
  );

  burst_reader #(
    .BURST_LEN (BURST_LEN)
  ) u_burst_reader (
    .ddr3_axi_clk   (ddr3_axi_clk),
    .i_rst          (i_rst),
    .i_has_released (has_released),
    .o_pop          (pop),
    .i_rd           (rd),
    .o_m_beat       (o_m_beat),
    .o_m_valid      (o_m_valid),
    .i_m_ready      (i_m_ready)
  );

endmodule : dram_fifo_top

// File: dram_fifo_types_pkg.sv
// --------------------------------------------------------------------------
// stream FIFO interconnect types
// beats, ring writes and ring read returns passed between the blocks
// --------------------------------------------------------------------------

package dram_fifo_types_pkg;

  // --------------------------------------------------------------------------
  // stream beat
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [dram_fifo_cfg_pkg::DATA_W-1:0] data;  // payload word
    logic                                 last;  // tlast of the beat
  } stream_beat_t;                               // 65 bits

  // --------------------------------------------------------------------------
  // writer to ring
  // --------------------------------------------------------------------------
  // rel makes every unreleased beat visible to the reader,
  // including a beat written in the same cycle
  typedef struct packed {
    stream_beat_t beat;  // beat to store
    logic         we;    // store beat at write pointer
    logic         rel;   // release all pending beats
  } mem_wr_t;            // 67 bits

  // --------------------------------------------------------------------------
  // ring to reader
  // --------------------------------------------------------------------------
  // valid exactly one cycle after a pop
  typedef struct packed {
    stream_beat_t beat;   // oldest released beat
    logic         valid;  // beat is present this cycle
  } mem_rd_t;             // 66 bits

endpackage : dram_fifo_types_pkg

// File: ring_buffer.sv
// --------------------------------------------------------------------------
// ring buffer
// dual-port beat memory with used and released counts, registered read data
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ring_buffer #(
  parameter int DEPTH_LOG2 = dram_fifo_cfg_pkg::DEF_DEPTH_LOG2
) (
  input  logic                         ddr3_axi_clk,
  input  logic                         i_rst,
  // write side
  input  dram_fifo_types_pkg::mem_wr_t i_wr,
  output logic                         o_full,
  // read side
  input  logic                         i_pop,
  output logic                         o_has_released,
  output dram_fifo_types_pkg::mem_rd_t o_rd
);

  import dram_fifo_types_pkg::*;

  localparam int DEPTH = 1 << DEPTH_LOG2;
  localparam int CNT_W = DEPTH_LOG2 + 1;  // holds 0..DEPTH

  stream_beat_t          mem [DEPTH];     // beat storage
  logic [DEPTH_LOG2-1:0] wr_ptr;          // next slot to write
  logic [DEPTH_LOG2-1:0] rd_ptr;          // oldest stored beat
  logic [CNT_W-1:0]      used_cnt;        // stored beats, released or not
  logic [CNT_W-1:0]      rel_cnt;         // released beats not yet popped
  logic [CNT_W-1:0]      used_nxt;

  assign o_full         = (used_cnt == CNT_W'(DEPTH));
  assign o_has_released = (rel_cnt != '0);

  always_comb begin
    used_nxt = used_cnt;
    if (i_wr.we) used_nxt = used_nxt + CNT_W'(1);
    if (i_pop)   used_nxt = used_nxt - CNT_W'(1);
  end

  // --------------------------------------------------------------------------
  // pointers and counts
  // --------------------------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      used_cnt   <= '0;
      rel_cnt    <= '0;
      o_rd.valid <= 1'b0;
    end else begin
      if (i_wr.we) wr_ptr <= wr_ptr + DEPTH_LOG2'(1);  // wraps at DEPTH
      if (i_pop)   rd_ptr <= rd_ptr + DEPTH_LOG2'(1);
      used_cnt <= used_nxt;
      if (i_wr.rel) begin
        rel_cnt <= used_nxt;                   // all stored beats now visible
      end else if (i_pop) begin
        rel_cnt <= rel_cnt - CNT_W'(1);
      end
      o_rd.valid <= i_pop;                     // data follows pop by one cycle
    end
  end

  // --------------------------------------------------------------------------
  // memory ports
  // --------------------------------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_wr.we) mem[wr_ptr] <= i_wr.beat;
    if (i_pop)   o_rd.beat   <= mem[rd_ptr];   // popped slot is never the written one
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  a_no_wr_full : assert property (
    @(posedge ddr3_axi_clk) disable iff (i_rst)
    !(i_wr.we && o_full)
  ) else $error("ring_buffer: write while full");

  a_no_pop_empty : assert property (
    @(posedge ddr3_axi_clk) disable iff (i_rst)
    !(i_pop && !o_has_released)
  ) else $error("ring_buffer: pop with nothing released");

endmodule : ring_buffer

// File: run_sim.sh
#!/bin/sh
# build and run the stream FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dram_fifo_top \
  -f dram_fifo_top.f -o sim_tb

status=0
out=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "No errors"; then
  echo "simulation passed"
else
  echo "simulation failed, exit status $status"
  exit 1
fi

// File: tb_dram_fifo_top.sv
// --------------------------------------------------------------------------
// stream FIFO testbench
// random traffic against a queue model, plus timeout, burst and capacity runs
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_dram_fifo_top;

  import dram_fifo_cfg_pkg::*;
  import dram_fifo_types_pkg::*;

  localparam int N_PART      = 5;                                 // partial group below burst size
  localparam int N_RAND      = 300;                               // beats in the random run
  localparam int CAP         = (1 << DEF_DEPTH_LOG2) + 2 * DEF_BURST_LEN;  // ring plus queue
  localparam int TOTAL_BEATS = N_PART + DEF_BURST_LEN + N_RAND + CAP + 1;
  localparam int PHASES      = 5;
  localparam int WD_CYCLES   = TOTAL_BEATS * 20 + PHASES * DEF_TIMEOUT * 4;
  localparam int DRAIN_MAX   = CAP * 4 + DEF_TIMEOUT * 4;         // worst case to empty

  logic         ddr3_axi_clk = 1'b0;
  logic         i_rst;
  stream_beat_t i_s_beat;
  logic         i_s_valid;
  logic         o_s_ready;
  stream_beat_t o_m_beat;
  logic         o_m_valid;
  logic         i_m_ready;

  integer       seed = 36;
  stream_beat_t model_q [$];    // beats accepted but not yet seen at output
  logic         in_fire;        // input transfer at the coming edge
  logic         out_fire;       // output transfer at the coming edge
  logic         mv_seen;        // o_m_valid sampled mid cycle
  logic         rdy_seen;       // o_s_ready sampled mid cycle

  dram_fifo_top i_dram_fifo_top (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst        (i_rst),
    .i_s_beat     (i_s_beat),
    .i_s_valid    (i_s_valid),
    .o_s_ready    (o_s_ready),
    .o_m_beat     (o_m_beat),
    .o_m_valid    (o_m_valid),
    .i_m_ready    (i_m_ready)
  );

  always #50 ddr3_axi_clk = ~ddr3_axi_clk;  // 100 ns period

  // --------------------------------------------------------------------------
  // checking helpers
  // --------------------------------------------------------------------------
  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_beat(input string name, input stream_beat_t exp,
                            input stream_beat_t act);
    if (exp !== act) begin
      $display("[ERROR] t=%0t %s expected data=%h last=%b actual data=%h last=%b",
               $time, name, exp.data, exp.last, act.data, act.last);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  function automatic stream_beat_t rand_beat();
    stream_beat_t b;
    b.data = {$random(seed), $random(seed)};
    b.last = (($random(seed) & 1) != 0);
    return b;
  endfunction

  // --------------------------------------------------------------------------
  // cycle step and model update
  // --------------------------------------------------------------------------
  // sample at the falling edge while inputs move 1 ns after the rising edge
  task automatic tick();
    @(negedge ddr3_axi_clk);
    in_fire  = i_s_valid && o_s_ready;
    out_fire = o_m_valid && i_m_ready;
    mv_seen  = o_m_valid;
    rdy_seen = o_s_ready;
    if (in_fire) model_q.push_back(i_s_beat);
    if (out_fire) begin
      if (model_q.size() == 0) begin
        $display("t=%0t output beat appeared with nothing left in the model", $time);
        stop_run();
      end else begin
        check_beat("o_m_beat", model_q[0], o_m_beat);
        void'(model_q.pop_front());
      end
    end
    @(posedge ddr3_axi_clk);
    #1;
  endtask

  // back to back beats with valid held until each transfer
  task automatic send_burst(input int n);
    for (int k = 0; k < n; k++) begin
      i_s_valid = 1'b1;
      i_s_beat  = rand_beat();
      tick();
      while (!in_fire) tick();
    end
    i_s_valid = 1'b0;
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    i_m_ready = 1'b1;
    while (model_q.size() != 0 && n < max_cycles) begin
      tick();
      n++;
    end
    if (model_q.size() != 0) begin
      $display("t=%0t drain left %0d beats behind after %0d cycles",
               $time, model_q.size(), max_cycles);
      stop_run();
    end else begin
      repeat (2) tick();                     // any stray beat hits an empty model
    end
  endtask

  // --------------------------------------------------------------------------
  // test phases
  // --------------------------------------------------------------------------
  // release comes TIMEOUT edges after the last beat, output two edges later
  task automatic test_partial();
    send_burst(N_PART);
    for (int k = 0; k < DEF_TIMEOUT + 2; k++) begin
      tick();
      check_bit("o_m_valid", 1'b0, mv_seen);  // group must wait for timeout
    end
    tick();
    check_bit("o_m_valid", 1'b1, mv_seen);    // timeout release reached the output
    drain(DRAIN_MAX);
  endtask

  task automatic test_full_group();
    int   lat;
    logic got;
    send_burst(DEF_BURST_LEN);
    lat = 0;
    got = 1'b0;
    while (!got && lat < 3) begin
      tick();
      lat++;
      got = mv_seen;
    end
    if (!got) begin
      $display("t=%0t full group gave no output within 3 cycles of its last beat", $time);
      stop_run();
    end else begin
      drain(DRAIN_MAX);
    end
  endtask

  task automatic test_random();
    int sent;
    sent = 0;
    while (sent < N_RAND) begin
      if (!i_s_valid && (($random(seed) & 1) != 0)) begin
        i_s_valid = 1'b1;
        i_s_beat  = rand_beat();
      end
      i_m_ready = (($random(seed) & 3) != 0);  // ready about 3 cycles in 4
      tick();
      if (in_fire) begin
        sent++;
        i_s_valid = 1'b0;
      end
    end
    drain(DRAIN_MAX);
  endtask

  task automatic test_backpressure();
    int   n;
    int   acc;
    logic full_seen;
    i_m_ready = 1'b0;
    i_s_valid = 1'b1;
    i_s_beat  = rand_beat();
    n         = 0;
    acc       = 0;
    full_seen = 1'b0;
    while (!full_seen && n < CAP * 4) begin
      tick();
      n++;
      if (in_fire) begin
        acc++;
        i_s_beat = rand_beat();
      end else if (!rdy_seen) begin
        full_seen = 1'b1;
      end
    end
    if (!full_seen) begin
      $display("t=%0t o_s_ready never fell with the output stalled", $time);
      stop_run();
    end else begin
      check_count("accepted beats at full", CAP, acc);
      i_m_ready = 1'b1;                      // pending beat still held valid
      n = 0;
      tick();
      while (!in_fire && n < DRAIN_MAX) begin
        tick();
        n++;
      end
      i_s_valid = 1'b0;
      if (!in_fire) begin
        $display("t=%0t held beat was never accepted after the output resumed", $time);
        stop_run();
      end else begin
        drain(DRAIN_MAX);                    // last beat needs the timeout
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    i_rst     = 1'b1;
    i_s_valid = 1'b0;
    i_s_beat  = '0;
    i_m_ready = 1'b0;
    repeat (4) @(posedge ddr3_axi_clk);
    #1;
    i_rst = 1'b0;
    tick();
    check_bit("o_m_valid", 1'b0, mv_seen);
    check_bit("o_s_ready", 1'b1, rdy_seen);
    test_partial();
    test_full_group();
    test_random();
    test_backpressure();
    if (model_q.size() != 0) begin
      $display("t=%0t model still holds %0d beats at the end", $time, model_q.size());
      stop_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge ddr3_axi_clk);
    $display("t=%0t watchdog expired after %0d cycles, the run did not finish",
             $time, WD_CYCLES);
    stop_run();
  end

endmodule : tb_dram_fifo_top
